// File: vlog.f
common/pzx_pkg.sv
rtl/tape_ram.sv
rtl/host_regs.sv
player/block_decoder.sv
player/pulse_timer.sv
rtl/pzx_player_top.sv
verification/pzx_player_props.sv
verification/tb_pzx_player.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_pzx_player \
    -Mdir obj_dir -o tb_pzx_player > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_pzx_player > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: verification/tb_pzx_player.sv
`timescale 1ns/1ps

module tb_pzx_player;
    import pzx_pkg::*;

    logic      clk;
    logic      arst_n;
    host_bus_t bus;
    byte_t     rdata;
    logic      play_in;
    logic      stop_in;
    logic      pulse_out;
    logic      playing;

    logic [31:0] lfsr_q = 32'h0e70dc53;
    int          cycle = 0;
    logic        last_level = 1'b0;
    int          ev_time[$];   // Cycle of each pulse_out change
    logic        ev_level[$];
    byte_t       tape[$];

    pzx_player_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .rdata     (rdata),
        .play_in   (play_in),
        .stop_in   (stop_in),
        .pulse_out (pulse_out),
        .playing   (playing)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Log of level changes, sampled on the falling edge
    always @(negedge clk) begin
        if (arst_n && pulse_out !== last_level) begin
            ev_time.push_back(cycle);
            ev_level.push_back(pulse_out);
        end
        last_level = pulse_out;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_span(input string name, input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Waits, stimulus and tape building
    // ------------------------------------------------------------
    task automatic wait_playing(input logic level);
        int t;
        t = 0;
        @(negedge clk);
        while (playing !== level) begin
            @(negedge clk);
            t++;
            if (t > 2000) begin
                report_error($sformatf("playing did not become %0d in time", level));
            end
        end
    endtask

    task automatic wait_events(input int n);
        int t;
        t = 0;
        while (ev_time.size() < n) begin
            @(negedge clk);
            t++;
            if (t > 5000) begin
                report_error($sformatf("saw %0d of %0d pulse_out edges", ev_time.size(), n));
            end
        end
    endtask

    task automatic clear_events();
        ev_time.delete();
        ev_level.delete();
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic next_byte(output byte_t b);
        int k;
        b = '0;
        for (k = 0; k < 8; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b = {b[6:0], lfsr_q[0]};
        end
    endtask

    // Strobes stay high 2 cycles and low at least 2
    task automatic host_write(input byte_t addr, input byte_t data);
        @(posedge clk);
        bus.addr  <= addr;
        bus.wdata <= data;
        bus.wr    <= 1'b1;
        repeat (2) @(posedge clk);
        bus.wr <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic host_read(input byte_t addr, output byte_t data);
        @(posedge clk);
        bus.addr <= addr;
        bus.rd   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        data = rdata;   // Valid from the second strobe cycle
        @(posedge clk);
        bus.rd <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic set_addr(input tape_addr_t addr);
        host_write(reg_addr, {4'h0, addr[11:8]});
        host_write(reg_addr, addr[7:0]);
    endtask

    task automatic load_tape(input tape_addr_t base);
        int i;
        set_addr(base);
        for (i = 0; i < tape.size(); i++) begin
            host_write(reg_data_inc, tape[i]);
        end
    endtask

    task automatic add_header(input byte_t tag, input logic [31:0] len);
        tape.push_back(tag);
        tape.push_back(len[7:0]);
        tape.push_back(len[15:8]);
        tape.push_back(len[23:16]);
        tape.push_back(len[31:24]);
    endtask

    task automatic add_word(input logic [15:0] w);
        tape.push_back(w[7:0]);
        tape.push_back(w[15:8]);
    endtask

    task automatic press_play();
        @(posedge clk);
        play_in <= 1'b1;
        wait_playing(1'b1);
        @(posedge clk);
        play_in <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic press_stop();
        @(posedge clk);
        stop_in <= 1'b1;
        repeat (3) @(posedge clk);
        stop_in <= 1'b0;
        wait_playing(1'b0);
    endtask

    // skip counts the edge from the block's level reset to 0
    task automatic check_train(input int skip, input int total, input int spaced, input int span);
        int i;
        wait_events(total);
        repeat (200) @(negedge clk);
        check_count("pulse_out edges", ev_time.size(), total);
        check_flag("pulse_out first toggle", ev_level[skip], 1'b1);
        for (i = skip + 1; i < skip + spaced; i++) begin
            check_span("pulse_out period", ev_time[i] - ev_time[i - 1], span);
        end
        check_flag("pulse_out", pulse_out, ((total - skip) % 2) == 1);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_register_port();
        byte_t data [16];
        byte_t got;
        int    i;
        for (i = 0; i < 16; i++) begin
            next_byte(data[i]);
        end
        set_addr(12'h5a0);
        for (i = 0; i < 16; i++) begin
            host_write(reg_data_inc, data[i]);
        end
        set_addr(12'h5a0);
        for (i = 0; i < 16; i++) begin
            host_read(reg_data_inc, got);
            check_byte("rdata", got, data[i]);
        end
        set_addr(12'h5a5);
        host_read(reg_data, got);
        check_byte("rdata", got, data[5]);
        host_read(reg_data, got);   // Pointer must not have moved
        check_byte("rdata", got, data[5]);
    endtask

    task automatic test_pulse_train();
        check_flag("pulse_out", pulse_out, 1'b0);
        tape.delete();
        add_header(tag_pulse, 4);
        add_word(16'h8005);   // Count 5
        add_word(16'h0003);
        add_header(tag_stop, 0);
        load_tape(12'h000);
        clear_events();
        press_play();
        wait_playing(1'b0);
        check_train(0, 5, 5, 8 * 3 + 1);
    endtask

    task automatic test_long_and_zero();
        logic pre;
        press_stop();
        tape.delete();
        add_header(tag_pulse, 10);
        add_word(16'h8002);
        add_word(16'h8000);   // Extended duration, high part
        add_word(16'h0006);
        add_word(16'h8003);   // Count 3 at duration 0
        add_word(16'h0000);
        add_header(tag_stop, 0);
        load_tape(12'h000);
        @(negedge clk);
        pre = pulse_out;
        clear_events();
        press_play();
        wait_playing(1'b0);
        check_train(int'(pre), int'(pre) + 3, 2, 8 * 6 + 1);
    endtask

    task automatic test_pause_stop();
        logic pre;
        press_stop();
        tape.delete();
        add_header(tag_pause, 4);
        add_word(16'h0000);   // Short pause at level 0
        add_word(16'h0000);
        add_header(tag_pause, 4);
        add_word(16'h0003);
        add_word(16'h8000);   // Level bit
        add_header(tag_stop, 0);
        add_header(tag_pulse, 4);
        add_word(16'h8002);
        add_word(16'h0002);
        add_header(tag_stop, 0);
        load_tape(12'h000);
        @(negedge clk);
        pre = pulse_out;
        clear_events();
        press_play();
        wait_playing(1'b0);
        repeat (8 * 3 + 1 + 16) @(negedge clk);
        check_flag("pulse_out", pulse_out, 1'b1);
        check_count("pulse_out edges", ev_time.size(), pre ? 2 : 1);

        // Resume with the block after the STOP
        pre = pulse_out;
        clear_events();
        press_play();
        wait_playing(1'b0);
        check_train(int'(pre), int'(pre) + 2, 2, 8 * 2 + 1);
    endtask

    task automatic test_stop_pin();
        logic pre;
        logic lvl;
        int   n;
        press_stop();
        tape.delete();
        add_header(tag_pulse, 8);
        add_word(16'h8064);
        add_word(16'h0004);
        add_word(16'h8064);
        add_word(16'h0004);
        add_header(tag_pulse, 4);   // Reached only if play resumes here
        add_word(16'h8002);
        add_word(16'h0004);
        load_tape(12'h000);
        @(negedge clk);
        pre = pulse_out;
        clear_events();
        press_play();
        wait_events(int'(pre) + 3);
        press_stop();
        lvl = pulse_out;
        n   = ev_time.size();
        repeat (100) @(negedge clk);
        check_flag("pulse_out", pulse_out, lvl);
        check_count("pulse_out edges", ev_time.size(), n);

        set_addr(12'h000);
        host_write(reg_data, 8'h07);   // Unknown tag at the start
        press_play();
        wait_playing(1'b0);
        repeat (100) @(negedge clk);
        check_count("pulse_out edges", ev_time.size(), n);
        check_flag("playing", playing, 1'b0);
    endtask

    initial begin
        arst_n  = 1'b0;
        bus     = '0;
        play_in = 1'b0;
        stop_in = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("playing", playing, 1'b0);
        check_flag("pulse_out", pulse_out, 1'b0);

        test_register_port();
        test_pulse_train();
        test_long_and_zero();
        test_pause_stop();
        test_stop_pin();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verification/pzx_player_props.sv
`timescale 1ns/1ps

module pzx_player_props (
    input logic                clk,
    input logic                arst_n,
    input pzx_pkg::timer_cmd_t cmd,
    input logic                cmd_valid,
    input logic                cmd_ready,
    input logic                pulse_out,
    input logic                busy,
    input logic                expire
);

    // Decoder holds its command under back-pressure
    cmd_held: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid && !cmd_ready |=> $stable(cmd))
        else $error("cmd changed while cmd_ready was low");

    level_held: assert property (@(posedge clk) disable iff (!arst_n)
        busy && !expire |=> $stable(pulse_out))
        else $error("pulse_out changed between expiries");

    reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> cmd_ready && !pulse_out)
        else $error("timer not idle after reset");   // Idle, level low

endmodule

bind pulse_timer pzx_player_props props_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .pulse_out (pulse_out),
    .busy      (busy_q),
    .expire    (expire)
);

// File: rtl/pzx_player_top.sv
`timescale 1ns/1ps

module pzx_player_top (
    input  logic               clk,
    input  logic               arst_n,
    input  pzx_pkg::host_bus_t bus,
    output pzx_pkg::byte_t     rdata,
    input  logic               play_in,
    input  logic               stop_in,
    output logic               pulse_out,
    output logic               playing
);
    import pzx_pkg::*;

    tape_addr_t host_addr;
    logic       host_we;
    byte_t      host_rdata;
    tape_addr_t rd_addr;
    byte_t      rd_data;
    logic       play_toggle;
    logic       stop_req;
    timer_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_ready;

    tape_ram ram_i (
        .clk        (clk),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (bus.wdata),
        .host_rdata (host_rdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    host_regs regs_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (bus),
        .playing     (playing),
        .host_rdata  (host_rdata),
        .rdata       (rdata),
        .host_addr   (host_addr),
        .host_we     (host_we),
        .play_in     (play_in),
        .stop_in     (stop_in),
        .play_toggle (play_toggle),
        .stop_req    (stop_req)
    );

    block_decoder dec_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .play_toggle (play_toggle),
        .stop_req    (stop_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .playing     (playing)
    );

    // Stop button also aborts the running command
    pulse_timer timer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .abort     (stop_req),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .pulse_out (pulse_out)
    );

endmodule

// File: player/pulse_timer.sv
`timescale 1ns/1ps

module pulse_timer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                abort,
    input  pzx_pkg::timer_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output logic                pulse_out
);
    import pzx_pkg::*;

    localparam int cnt_w = $bits(duration_t) + dur_scale_log2;

    logic             busy_q;
    logic             level_q;
    logic             hold_q;
    duration_t        dur_q;
    pulse_count_t     remain_q;
    logic [cnt_w-1:0] cnt_q;
    logic             accept;
    logic             expire;
    logic             zero_dur;
    logic             base_level;

    assign cmd_ready  = ~busy_q;
    assign pulse_out  = level_q;
    assign accept     = cmd_valid & cmd_ready;
    assign expire     = busy_q && (cnt_q == {dur_q, {dur_scale_log2{1'b0}}});
    assign zero_dur   = (cmd.duration == '0);
    assign base_level = cmd.set_level ? cmd.level : level_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            level_q <= 1'b0;
        end else if (abort) begin
            busy_q <= 1'b0;   // Level stays where it is
        end else if (accept) begin
            if (cmd.hold) begin
                level_q <= base_level;
                busy_q  <= 1'b1;
            end else if (zero_dur) begin
                level_q <= base_level ^ cmd.count[0];   // Odd count flips once
            end else begin
                level_q <= base_level;
                busy_q  <= (cmd.count != '0);
            end
        end else if (expire) begin
            if (!hold_q) begin
                level_q <= ~level_q;
            end
            if (hold_q || remain_q == pulse_count_t'(1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Duration counter, 8*D+1 cycles per period
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q   <= cmd.hold;
            dur_q    <= cmd.duration;
            remain_q <= cmd.count;
            cnt_q    <= '0;
        end else if (expire) begin
            remain_q <= remain_q - pulse_count_t'(1);
            cnt_q    <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + cnt_w'(1);
        end
    end

endmodule

// File: player/block_decoder.sv
`timescale 1ns/1ps

module block_decoder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                play_toggle,
    input  logic                stop_req,
    output pzx_pkg::tape_addr_t rd_addr,
    input  pzx_pkg::byte_t      rd_data,
    output pzx_pkg::timer_cmd_t cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output logic                playing
);
    import pzx_pkg::*;

    typedef enum logic [2:0] {
        ST_TAG,
        ST_LEN,
        ST_PAUSE,
        ST_PWORD,
        ST_PDUR,
        ST_PEXT,
        ST_ISSUE
    } state_t;

    state_t      state_q;
    tape_addr_t  ptr_q;
    logic        phase_q;      // rd_data holds the byte at ptr_q
    logic [1:0]  byte_cnt_q;
    logic [1:0]  last_byte;
    logic [31:0] field_q;
    logic [31:0] field_next;
    logic [15:0] word;
    byte_t       tag_q;
    logic [31:0] len_q;
    logic        first_q;      // Next pulse command opens its block
    timer_cmd_t  cmd_q;
    logic        playing_q;

    always_comb begin
        case (state_q)
            ST_TAG:           last_byte = 2'd0;
            ST_LEN, ST_PAUSE: last_byte = 2'd3;
            default:          last_byte = 2'd1;
        endcase
    end

    // Little endian fields fill from the top
    assign field_next = {rd_data, field_q[31:8]};
    assign word       = field_next[31:16];

    assign rd_addr   = ptr_q;
    assign cmd       = cmd_q;
    assign cmd_valid = (state_q == ST_ISSUE);
    assign playing   = playing_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_TAG;
            ptr_q      <= '0;
            phase_q    <= 1'b0;
            byte_cnt_q <= 2'd0;
            field_q    <= '0;
            tag_q      <= '0;
            len_q      <= '0;
            first_q    <= 1'b0;
            cmd_q      <= '0;
            playing_q  <= 1'b0;
        end else if (stop_req) begin
            playing_q  <= 1'b0;
            ptr_q      <= '0;
            state_q    <= ST_TAG;
            phase_q    <= 1'b0;
            byte_cnt_q <= 2'd0;
        end else begin
            if (play_toggle) begin
                playing_q <= ~playing_q;
            end
            if (state_q == ST_ISSUE) begin
                if (cmd_ready) begin
                    first_q <= 1'b0;
                    state_q <= cmd_q.hold ? ST_TAG : ST_PWORD;
                end
            end else if (playing_q && state_q == ST_PWORD && len_q == '0) begin
                state_q <= ST_TAG;   // Block used up
            end else if (playing_q && !phase_q) begin
                phase_q <= 1'b1;
            end else if (playing_q) begin
                phase_q <= 1'b0;
                field_q <= field_next;
                ptr_q   <= ptr_q + tape_addr_t'(1);
                if (byte_cnt_q != last_byte) begin
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                end else begin
                    byte_cnt_q <= 2'd0;
                    case (state_q)
                        ST_TAG: begin
                            tag_q   <= rd_data;
                            state_q <= ST_LEN;
                        end
                        ST_LEN: begin
                            len_q   <= field_next;
                            state_q <= ST_TAG;
                            case (tag_q)
                                tag_pulse: begin
                                    first_q <= 1'b1;
                                    state_q <= ST_PWORD;
                                end
                                tag_pause: state_q <= ST_PAUSE;
                                tag_stop: begin
                                    playing_q <= 1'b0;
                                    ptr_q <= ptr_q + tape_addr_t'(1)
                                           + field_next[tape_addr_w-1:0];
                                end
                                default: begin
                                    playing_q <= 1'b0;   // Full stop, rewind
                                    ptr_q     <= '0;
                                end
                            endcase
                        end
                        ST_PAUSE: begin
                            cmd_q.hold      <= 1'b1;
                            cmd_q.set_level <= 1'b1;
                            cmd_q.level     <= field_next[31];
                            cmd_q.count     <= pulse_count_t'(1);
                            cmd_q.duration  <= field_next[30:0];
                            state_q         <= ST_ISSUE;
                        end
                        ST_PWORD, ST_PDUR: begin
                            len_q <= len_q - 32'd2;
                            if (state_q == ST_PWORD) begin
                                cmd_q.hold      <= 1'b0;
                                cmd_q.set_level <= first_q;
                                cmd_q.level     <= 1'b0;
                                cmd_q.count     <= pulse_count_t'(1);
                            end
                            if (state_q == ST_PWORD && word > 16'h8000) begin
                                cmd_q.count <= word[14:0];   // Repeat count word
                                state_q     <= ST_PDUR;
                            end else if (word[15]) begin
                                cmd_q.duration <= {word[14:0], 16'h0000};
                                state_q        <= ST_PEXT;
                            end else begin
                                cmd_q.duration <= {15'h0000, word};
                                state_q        <= ST_ISSUE;
                            end
                        end
                        ST_PEXT: begin
                            len_q                <= len_q - 32'd2;
                            cmd_q.duration[15:0] <= word;
                            state_q              <= ST_ISSUE;
                        end
                        default: state_q <= ST_TAG;
                    endcase
                end
            end
        end
    end

endmodule

// File: rtl/host_regs.sv
`timescale 1ns/1ps

module host_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pzx_pkg::host_bus_t   bus,
    input  logic                 playing,
    input  pzx_pkg::byte_t       host_rdata,
    output pzx_pkg::byte_t       rdata,
    output pzx_pkg::tape_addr_t  host_addr,
    output logic                 host_we,
    input  logic                 play_in,
    input  logic                 stop_in,
    output logic                 play_toggle,
    output logic                 stop_req
);
    import pzx_pkg::*;

    logic       rd_q;
    logic       wr_q;
    logic       inc_pend_q;
    tape_addr_t ptr_q;
    logic [1:0] play_sync_q;
    logic [1:0] stop_sync_q;
    logic       data_sel;
    logic       rd_rise;
    logic       wr_rise;
    logic       strobe_end;

    // ------------------------------------------------------------
    // Strobe edges and register decode
    // ------------------------------------------------------------
    assign data_sel   = (bus.addr == reg_data) || (bus.addr == reg_data_inc);
    assign rd_rise    = bus.rd & ~rd_q & ~playing;
    assign wr_rise    = bus.wr & ~wr_q & ~playing;
    assign strobe_end = (rd_q | wr_q) & ~bus.rd & ~bus.wr;

    assign host_addr = ptr_q;
    assign host_we   = wr_rise & data_sel;

    // RAM output is valid once the strobe has been high for a cycle
    assign rdata = (bus.rd && rd_q && data_sel && !playing) ? host_rdata : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q       <= 1'b0;
            wr_q       <= 1'b0;
            inc_pend_q <= 1'b0;
            ptr_q      <= '0;
        end else begin
            rd_q <= bus.rd;
            wr_q <= bus.wr;
            if ((rd_rise || wr_rise) && bus.addr == reg_data_inc) begin
                inc_pend_q <= 1'b1;
            end else if (strobe_end) begin
                inc_pend_q <= 1'b0;
                if (inc_pend_q) begin
                    ptr_q <= ptr_q + tape_addr_t'(1);
                end
            end
            if (wr_rise && bus.addr == reg_addr) begin
                ptr_q <= {ptr_q[tape_addr_w-9:0], bus.wdata};   // Shift in low byte
            end
        end
    end

    // ------------------------------------------------------------
    // Button synchronizers
    // ------------------------------------------------------------
    assign play_toggle = play_sync_q[0] & ~play_sync_q[1];
    assign stop_req    = stop_sync_q[0] & ~stop_sync_q[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            play_sync_q <= 2'b00;
            stop_sync_q <= 2'b00;
        end else begin
            play_sync_q <= {play_sync_q[0], play_in};
            stop_sync_q <= {stop_sync_q[0], stop_in};
        end
    end

endmodule

// File: rtl/tape_ram.sv
`timescale 1ns/1ps

module tape_ram (
    input  logic                clk,
    input  pzx_pkg::tape_addr_t host_addr,
    input  logic                host_we,
    input  pzx_pkg::byte_t      host_wdata,
    output pzx_pkg::byte_t      host_rdata,
    input  pzx_pkg::tape_addr_t rd_addr,
    output pzx_pkg::byte_t      rd_data
);
    import pzx_pkg::*;

    byte_t mem [0:(1 << tape_addr_w) - 1];

    // One write port, both reads registered
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
        rd_data    <= mem[rd_addr];   // Player side
    end

endmodule

// File: common/pzx_pkg.sv
package pzx_pkg;

    // ------------------------------------------------------------
    // Host registers and tape encoding
    // ------------------------------------------------------------
    localparam logic [7:0] reg_data     = 8'hfd;
    localparam logic [7:0] reg_data_inc = 8'hfc;
    localparam logic [7:0] reg_addr     = 8'hfb;

    localparam logic [7:0] tag_stop  = 8'd1;
    localparam logic [7:0] tag_pulse = 8'd2;
    localparam logic [7:0] tag_pause = 8'd4;   // Anything else is a full stop

    localparam int tape_addr_w    = 12;
    localparam int dur_scale_log2 = 3;         // One duration unit is 8 clocks

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef logic [7:0]             byte_t;
    typedef logic [tape_addr_w-1:0] tape_addr_t;
    typedef logic [30:0]            duration_t;
    typedef logic [14:0]            pulse_count_t;

    typedef struct packed {
        byte_t addr;
        logic  rd;
        logic  wr;
        byte_t wdata;
    } host_bus_t;

    // Hold marks a pause, otherwise the timer toggles count times
    typedef struct packed {
        logic         hold;
        logic         set_level;
        logic         level;
        pulse_count_t count;
        duration_t    duration;
    } timer_cmd_t;

endpackage
